//--- design/bp_pkg.sv
package bp_pkg;

    parameter int ADDR_BITS = 32;

    // pc or branch target
    typedef logic [ADDR_BITS-1:0] addr_t;

    // default table geometry, handed down by the top level
    parameter int DEF_NUM_WAYS     = 2;
    parameter int DEF_NUM_SETS     = 16;
    parameter int DEF_COUNTER_BITS = 2;
    parameter int DEF_UPD_DEPTH    = 4;

    // one resolved branch waiting in the update queue
    typedef struct packed {
        addr_t pc;
        addr_t target;
        logic  taken;
    } upd_entry_t;

    // index field sits just above the two byte-offset bits
    function automatic int index_bits(int num_sets);
        return $clog2(num_sets);
    endfunction

    // tag is everything above the index
    function automatic int tag_bits(int num_sets);
        return ADDR_BITS - 2 - index_bits(num_sets);
    endfunction

    function automatic addr_t index_of(addr_t pc, int num_sets);
        addr_t mask;
        mask = addr_t'(num_sets - 1);
        return (pc >> 2) & mask;
    endfunction

    function automatic addr_t tag_of(addr_t pc, int num_sets);
        return pc >> (2 + index_bits(num_sets));
    endfunction

endpackage

//--- design/bp_way_if.sv
`timescale 1ns/1ps

interface bp_way_if #(
    parameter int NUM_SETS     = bp_pkg::DEF_NUM_SETS,
    parameter int COUNTER_BITS = bp_pkg::DEF_COUNTER_BITS
) (
    input logic clk,
    input logic reset
);
    localparam int INDEX_BITS = bp_pkg::index_bits(NUM_SETS);
    localparam int TAG_BITS   = bp_pkg::tag_bits(NUM_SETS);

    // lookup addresses: fetch pc, pc+4 and the update queue head
    logic [INDEX_BITS-1:0]   pc_index;
    logic [TAG_BITS-1:0]     pc_tag;
    logic [INDEX_BITS-1:0]   pcp4_index;
    logic [TAG_BITS-1:0]     pcp4_tag;
    logic [INDEX_BITS-1:0]   upd_index;
    logic [TAG_BITS-1:0]     upd_tag;

    // write side, addressed by upd_index
    logic                    wr_en;
    logic                    wr_alloc;
    bp_pkg::addr_t           wr_target;
    logic [COUNTER_BITS-1:0] wr_counter;

    // per-port lookup results
    logic                    pc_hit;
    bp_pkg::addr_t           pc_target;
    logic [COUNTER_BITS-1:0] pc_counter;
    logic                    pcp4_hit;
    bp_pkg::addr_t           pcp4_target;
    logic [COUNTER_BITS-1:0] pcp4_counter;
    logic                    upd_hit;
    logic [COUNTER_BITS-1:0] upd_counter;

    modport feeder (
        output pc_index, pc_tag, pcp4_index, pcp4_tag, upd_index, upd_tag,
        output wr_en, wr_alloc, wr_target, wr_counter
    );

    modport way (
        input  pc_index, pc_tag, pcp4_index, pcp4_tag, upd_index, upd_tag,
        input  wr_en, wr_alloc, wr_target, wr_counter,
        output pc_hit, pc_target, pc_counter, pcp4_hit, pcp4_target, pcp4_counter,
        output upd_hit, upd_counter
    );

    modport drain (
        input clk, reset,
        input pc_hit, pc_target, pc_counter, pcp4_hit, pcp4_target, pcp4_counter,
        input upd_hit, upd_counter
    );

endinterface

//--- design/bp_way.sv
`timescale 1ns/1ps

module bp_way #(
    parameter int NUM_SETS     = bp_pkg::DEF_NUM_SETS,
    parameter int COUNTER_BITS = bp_pkg::DEF_COUNTER_BITS
) (
    input logic   clk,
    input logic   reset,
    bp_way_if.way port
);
    localparam int TAG_BITS = bp_pkg::tag_bits(NUM_SETS);

    logic [NUM_SETS-1:0]     valid;
    logic [TAG_BITS-1:0]     tags     [NUM_SETS];
    bp_pkg::addr_t           targets  [NUM_SETS];
    logic [COUNTER_BITS-1:0] counters [NUM_SETS];

    // only the valid bits come out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (port.wr_en && port.wr_alloc) begin
            valid[port.upd_index] <= 1'b1;
        end
    end

    // training rewrites just the counter
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            counters[port.upd_index] <= port.wr_counter;
            if (port.wr_alloc) begin
                tags[port.upd_index]    <= port.upd_tag;
                targets[port.upd_index] <= port.wr_target;
            end
        end
    end

    // fetch pc lookup
    assign port.pc_hit     = valid[port.pc_index] && (tags[port.pc_index] == port.pc_tag);
    assign port.pc_target  = targets[port.pc_index];
    assign port.pc_counter = counters[port.pc_index];

    // sequential pc+4 lookup
    assign port.pcp4_hit     = valid[port.pcp4_index] &&
                               (tags[port.pcp4_index] == port.pcp4_tag);
    assign port.pcp4_target  = targets[port.pcp4_index];
    assign port.pcp4_counter = counters[port.pcp4_index];

    // queue head lookup, feeds the training path
    assign port.upd_hit     = valid[port.upd_index] && (tags[port.upd_index] == port.upd_tag);
    assign port.upd_counter = counters[port.upd_index];

    // an allocation must never duplicate a tag already held here
    no_dup_alloc_a: assert property (@(posedge clk) disable iff (reset)
        (port.wr_en && port.wr_alloc) |-> !port.upd_hit)
        else $error("allocation into a set that already holds the tag");

endmodule

//--- design/bp_hit_merge.sv
`timescale 1ns/1ps

module bp_hit_merge #(
    parameter int NUM_WAYS     = bp_pkg::DEF_NUM_WAYS,
    parameter int COUNTER_BITS = bp_pkg::DEF_COUNTER_BITS,
    localparam int WAY_BITS    = $clog2(NUM_WAYS)
) (
    bp_way_if.drain                 ways [NUM_WAYS-1:0],
    output logic                    hit,
    output logic                    hit_pc,
    output logic                    hit_pcp4,
    output bp_pkg::addr_t           pred_target,
    output logic                    pred_taken,
    output logic [WAY_BITS-1:0]     pred_way,
    output logic                    upd_hit,
    output logic [WAY_BITS-1:0]     upd_way,
    output logic [COUNTER_BITS-1:0] upd_counter
);
    logic [NUM_WAYS-1:0]     pc_hit_v, pcp4_hit_v, upd_hit_v;
    bp_pkg::addr_t           pc_target_a   [NUM_WAYS];
    bp_pkg::addr_t           pcp4_target_a [NUM_WAYS];
    logic [COUNTER_BITS-1:0] pc_counter_a  [NUM_WAYS];
    logic [COUNTER_BITS-1:0] pcp4_counter_a[NUM_WAYS];
    logic [COUNTER_BITS-1:0] upd_counter_a [NUM_WAYS];
    logic [WAY_BITS-1:0]     pc_way, pcp4_way;
    logic                    chk_clk, chk_reset;

    // flatten the interface array
    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        assign pc_hit_v[i]       = ways[i].pc_hit;
        assign pcp4_hit_v[i]     = ways[i].pcp4_hit;
        assign upd_hit_v[i]      = ways[i].upd_hit;
        assign pc_target_a[i]    = ways[i].pc_target;
        assign pcp4_target_a[i]  = ways[i].pcp4_target;
        assign pc_counter_a[i]   = ways[i].pc_counter;
        assign pcp4_counter_a[i] = ways[i].pcp4_counter;
        assign upd_counter_a[i]  = ways[i].upd_counter;
    end

    assign chk_clk   = ways[0].clk;
    assign chk_reset = ways[0].reset;

    // hit flags to way numbers
    always_comb begin
        pc_way   = '0;
        pcp4_way = '0;
        upd_way  = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (pc_hit_v[i]) begin
                pc_way = WAY_BITS'(i);
            end
            if (pcp4_hit_v[i]) begin
                pcp4_way = WAY_BITS'(i);
            end
            if (upd_hit_v[i]) begin
                upd_way = WAY_BITS'(i);
            end
        end
    end

    assign hit_pc   = |pc_hit_v;
    assign hit_pcp4 = |pcp4_hit_v;
    assign hit      = hit_pc || hit_pcp4;

    // pc side wins over pc+4
    assign pred_way    = hit_pc ? pc_way : pcp4_way;
    assign pred_target = hit_pc   ? pc_target_a[pc_way] :
                         hit_pcp4 ? pcp4_target_a[pcp4_way] : '0;
    assign pred_taken  = hit_pc   ? pc_counter_a[pc_way][COUNTER_BITS-1] :
                         hit_pcp4 ? pcp4_counter_a[pcp4_way][COUNTER_BITS-1] : 1'b0;

    assign upd_hit     = |upd_hit_v;
    assign upd_counter = upd_counter_a[upd_way];

    // tags are unique within a set across all ways
    one_hit_a: assert property (@(posedge chk_clk) disable iff (chk_reset)
        $onehot0(pc_hit_v) && $onehot0(pcp4_hit_v) && $onehot0(upd_hit_v))
        else $error("more than one way hit on a read port");

endmodule

//--- design/bp_update_ctrl.sv
`timescale 1ns/1ps

module bp_update_ctrl #(
    parameter int NUM_WAYS     = bp_pkg::DEF_NUM_WAYS,
    parameter int NUM_SETS     = bp_pkg::DEF_NUM_SETS,
    parameter int COUNTER_BITS = bp_pkg::DEF_COUNTER_BITS,
    parameter int UPD_DEPTH    = bp_pkg::DEF_UPD_DEPTH,
    localparam int WAY_BITS    = $clog2(NUM_WAYS)
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    upd_valid,
    input  bp_pkg::addr_t           upd_pc,
    input  bp_pkg::addr_t           upd_target,
    input  logic                    upd_taken,
    output logic                    upd_credit,
    input  bp_pkg::addr_t           pred_pc,
    input  logic                    upd_hit,
    input  logic [WAY_BITS-1:0]     upd_way,
    input  logic [COUNTER_BITS-1:0] upd_counter,
    // pred_hit is the pc-side hit, pred_hit_pcp4 the pc+4 side
    input  logic                    pred_hit,
    input  logic                    pred_hit_pcp4,
    input  logic [WAY_BITS-1:0]     pred_way,
    bp_way_if.feeder                ways [NUM_WAYS-1:0]
);
    localparam int INDEX_BITS = bp_pkg::index_bits(NUM_SETS);
    localparam int TAG_BITS   = bp_pkg::tag_bits(NUM_SETS);
    localparam int PTR_BITS   = (UPD_DEPTH > 1) ? $clog2(UPD_DEPTH) : 1;
    localparam int CNT_BITS   = $clog2(UPD_DEPTH + 1);

    bp_pkg::upd_entry_t      queue [UPD_DEPTH];
    bp_pkg::upd_entry_t      head;
    logic [PTR_BITS-1:0]     wr_ptr, rd_ptr;
    logic [CNT_BITS-1:0]     count;
    logic                    retire;
    bp_pkg::addr_t           pcp4_pc;
    logic [INDEX_BITS-1:0]   pc_index, pcp4_index, head_index, pred_index;
    logic [TAG_BITS-1:0]     pc_tag, pcp4_tag, head_tag;
    logic [NUM_WAYS-2:0]     plru [NUM_SETS];
    logic [WAY_BITS-1:0]     victim, wr_way;
    logic                    do_train, do_alloc, pred_touch;
    logic [COUNTER_BITS-1:0] trained, wr_counter;
    logic [NUM_WAYS-1:0]     wr_en_vec;

    function automatic logic [PTR_BITS-1:0] next_ptr(logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(UPD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // walk the tree: each node bit names the colder half
    function automatic logic [WAY_BITS-1:0] plru_victim(logic [NUM_WAYS-2:0] tree);
        int                  node;
        logic                b;
        logic [WAY_BITS-1:0] way;
        node = 0;
        way  = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            b    = tree[node];
            way  = (way << 1) | WAY_BITS'(b);
            node = 2 * node + 1 + int'(b);
        end
        return way;
    endfunction

    // point every node on the path away from the touched way
    function automatic logic [NUM_WAYS-2:0] plru_touch(logic [NUM_WAYS-2:0] tree,
                                                      logic [WAY_BITS-1:0] way);
        int                  node;
        logic                b;
        logic [NUM_WAYS-2:0] t;
        t    = tree;
        node = 0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            b       = way[WAY_BITS-1-lvl];
            t[node] = ~b;
            node    = 2 * node + 1 + int'(b);
        end
        return t;
    endfunction

    // queue payload
    always_ff @(posedge clk) begin
        if (upd_valid) begin
            queue[wr_ptr] <= '{pc: upd_pc, target: upd_target, taken: upd_taken};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (upd_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (retire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_BITS'(upd_valid) - CNT_BITS'(retire);
        end
    end

    // one entry retires every cycle the queue holds anything
    assign retire     = (count != '0);
    assign upd_credit = retire;
    assign head       = queue[rd_ptr];

    assign pcp4_pc    = pred_pc + bp_pkg::ADDR_BITS'(4);
    assign pc_index   = INDEX_BITS'(bp_pkg::index_of(pred_pc, NUM_SETS));
    assign pc_tag     = TAG_BITS'(bp_pkg::tag_of(pred_pc, NUM_SETS));
    assign pcp4_index = INDEX_BITS'(bp_pkg::index_of(pcp4_pc, NUM_SETS));
    assign pcp4_tag   = TAG_BITS'(bp_pkg::tag_of(pcp4_pc, NUM_SETS));
    assign head_index = INDEX_BITS'(bp_pkg::index_of(head.pc, NUM_SETS));
    assign head_tag   = TAG_BITS'(bp_pkg::tag_of(head.pc, NUM_SETS));

    // saturating counter step
    always_comb begin
        trained = upd_counter;
        if (head.taken && upd_counter != '1) begin
            trained = upd_counter + 1'b1;
        end else if (!head.taken && upd_counter != '0) begin
            trained = upd_counter - 1'b1;
        end
    end

    assign victim     = plru_victim(plru[head_index]);
    assign do_train   = retire && upd_hit;
    assign do_alloc   = retire && !upd_hit && head.taken;
    assign wr_way     = upd_hit ? upd_way : victim;
    assign wr_counter = do_alloc ? '1 : trained;

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        assign wr_en_vec[i]      = (do_train || do_alloc) && (wr_way == WAY_BITS'(i));
        assign ways[i].pc_index   = pc_index;
        assign ways[i].pc_tag     = pc_tag;
        assign ways[i].pcp4_index = pcp4_index;
        assign ways[i].pcp4_tag   = pcp4_tag;
        assign ways[i].upd_index  = head_index;
        assign ways[i].upd_tag    = head_tag;
        assign ways[i].wr_en      = wr_en_vec[i];
        assign ways[i].wr_alloc   = do_alloc;
        assign ways[i].wr_target  = head.target;
        assign ways[i].wr_counter = wr_counter;
    end

    assign pred_touch = pred_hit || pred_hit_pcp4;
    assign pred_index = pred_hit ? pc_index : pcp4_index;

    // allocation takes the set when both touch the same one
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru[s] <= '0;
            end
        end else begin
            if (pred_touch && !(do_alloc && pred_index == head_index)) begin
                plru[pred_index] <= plru_touch(plru[pred_index], pred_way);
            end
            if (do_alloc) begin
                plru[head_index] <= plru_touch(plru[head_index], victim);
            end
        end
    end

    overflow_a: assert property (@(posedge clk) disable iff (reset)
        upd_valid |-> count < CNT_BITS'(UPD_DEPTH))
        else $error("update queue overflow");

endmodule

//--- design/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int NUM_WAYS     = bp_pkg::DEF_NUM_WAYS,
    parameter int NUM_SETS     = bp_pkg::DEF_NUM_SETS,
    parameter int COUNTER_BITS = bp_pkg::DEF_COUNTER_BITS,
    parameter int UPD_DEPTH    = bp_pkg::DEF_UPD_DEPTH,
    localparam int WAY_BITS    = $clog2(NUM_WAYS)
) (
    input  logic          clk,
    input  logic          reset,
    // prediction
    input  bp_pkg::addr_t pred_pc,
    output logic          hit,
    output logic          hit_pc,
    output logic          hit_pcp4,
    output bp_pkg::addr_t pred_target,
    output logic          pred_taken,
    // resolved branches from execute
    input  logic          upd_valid,
    input  bp_pkg::addr_t upd_pc,
    input  bp_pkg::addr_t upd_target,
    input  logic          upd_taken,
    output logic          upd_credit
);
    logic                    upd_hit;
    logic [WAY_BITS-1:0]     upd_way;
    logic [COUNTER_BITS-1:0] upd_counter;
    logic [WAY_BITS-1:0]     pred_way;

    bp_way_if #(
        .NUM_SETS    (NUM_SETS),
        .COUNTER_BITS(COUNTER_BITS)
    ) ways [NUM_WAYS-1:0] (
        .clk  (clk),
        .reset(reset)
    );

    bp_update_ctrl #(
        .NUM_WAYS    (NUM_WAYS),
        .NUM_SETS    (NUM_SETS),
        .COUNTER_BITS(COUNTER_BITS),
        .UPD_DEPTH   (UPD_DEPTH)
    ) update_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .upd_valid    (upd_valid),
        .upd_pc       (upd_pc),
        .upd_target   (upd_target),
        .upd_taken    (upd_taken),
        .upd_credit   (upd_credit),
        .pred_pc      (pred_pc),
        .upd_hit      (upd_hit),
        .upd_way      (upd_way),
        .upd_counter  (upd_counter),
        .pred_hit     (hit_pc),
        .pred_hit_pcp4(hit_pcp4),
        .pred_way     (pred_way),
        .ways         (ways)
    );

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
        bp_way #(
            .NUM_SETS    (NUM_SETS),
            .COUNTER_BITS(COUNTER_BITS)
        ) way_i (
            .clk  (clk),
            .reset(reset),
            .port (ways[i])
        );
    end

    bp_hit_merge #(
        .NUM_WAYS    (NUM_WAYS),
        .COUNTER_BITS(COUNTER_BITS)
    ) hit_merge_i (
        .ways       (ways),
        .hit        (hit),
        .hit_pc     (hit_pc),
        .hit_pcp4   (hit_pcp4),
        .pred_target(pred_target),
        .pred_taken (pred_taken),
        .pred_way   (pred_way),
        .upd_hit    (upd_hit),
        .upd_way    (upd_way),
        .upd_counter(upd_counter)
    );

endmodule

//--- test/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

    localparam int NUM_WAYS        = bp_pkg::DEF_NUM_WAYS;
    localparam int NUM_SETS        = bp_pkg::DEF_NUM_SETS;
    localparam int COUNTER_BITS    = bp_pkg::DEF_COUNTER_BITS;
    localparam int UPD_DEPTH       = bp_pkg::DEF_UPD_DEPTH;
    localparam int WAY_LEVELS      = $clog2(NUM_WAYS);
    localparam int SET_SHIFT       = $clog2(NUM_SETS);
    localparam int CTR_MAX         = (1 << COUNTER_BITS) - 1;
    localparam int CLK_PERIOD      = 40;
    localparam int STIM_DELAY      = 2;
    localparam int RANDOM_CYCLES   = 400;
    localparam int DIRECTED_CYCLES = 300;
    localparam int MARGIN_CYCLES   = 200;
    localparam bp_pkg::addr_t IDLE_PC = 32'hf000_0038;
    // per-update direction and the expected pred_taken after it
    localparam logic [5:0] TRAIN_TAKEN = 6'b110000;
    localparam logic [5:0] TRAIN_DIR   = 6'b100001;

    typedef struct packed {
        logic          hit_pc;
        logic          hit_pcp4;
        bp_pkg::addr_t target;
        logic          taken;
    } pred_t;

    logic          clk;
    logic          reset;
    bp_pkg::addr_t pred_pc;
    logic          hit;
    logic          hit_pc;
    logic          hit_pcp4;
    bp_pkg::addr_t pred_target;
    logic          pred_taken;
    logic          upd_valid;
    bp_pkg::addr_t upd_pc;
    bp_pkg::addr_t upd_target;
    logic          upd_taken;
    logic          upd_credit;

    // software copy of the table
    bit                  m_valid  [NUM_WAYS][NUM_SETS];
    bp_pkg::addr_t       m_tag    [NUM_WAYS][NUM_SETS];
    bp_pkg::addr_t       m_target [NUM_WAYS][NUM_SETS];
    int                  m_ctr    [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-2:0] m_plru   [NUM_SETS];
    bp_pkg::upd_entry_t  pending  [$];

    integer seed;
    string  test_name;
    int     credits;
    int     sent_count;
    int     returned_count;
    int     retired_count;
    int     addr_errors;
    int     flag_errors;
    int     count_errors;

    branch_predictor #(
        .NUM_WAYS    (NUM_WAYS),
        .NUM_SETS    (NUM_SETS),
        .COUNTER_BITS(COUNTER_BITS),
        .UPD_DEPTH   (UPD_DEPTH)
    ) branch_predictor_i (
        .clk        (clk),
        .reset      (reset),
        .pred_pc    (pred_pc),
        .hit        (hit),
        .hit_pc     (hit_pc),
        .hit_pcp4   (hit_pcp4),
        .pred_target(pred_target),
        .pred_taken (pred_taken),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_target (upd_target),
        .upd_taken  (upd_taken),
        .upd_credit (upd_credit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic int set_of(bp_pkg::addr_t pc);
        return int'((pc >> 2) % bp_pkg::addr_t'(NUM_SETS));
    endfunction

    function automatic bp_pkg::addr_t tag_part(bp_pkg::addr_t pc);
        return pc >> (2 + SET_SHIFT);
    endfunction

    function automatic int find_way(bp_pkg::addr_t pc);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[w][set_of(pc)] && m_tag[w][set_of(pc)] == tag_part(pc)) begin
                return w;
            end
        end
        return -1;
    endfunction

    // heap-numbered tree, node n has children 2n and 2n+1
    function automatic int victim_of(logic [NUM_WAYS-2:0] tree);
        int node;
        node = 1;
        for (int lvl = 0; lvl < WAY_LEVELS; lvl++) begin
            node = 2 * node + int'(tree[node-1]);
        end
        return node - NUM_WAYS;
    endfunction

    function automatic logic [NUM_WAYS-2:0] touched(logic [NUM_WAYS-2:0] tree, int way);
        int                  node;
        int                  b;
        logic [NUM_WAYS-2:0] t;
        t    = tree;
        node = 1;
        for (int lvl = 0; lvl < WAY_LEVELS; lvl++) begin
            b         = (way >> (WAY_LEVELS - 1 - lvl)) & 1;
            t[node-1] = (b == 0);
            node      = 2 * node + b;
        end
        return t;
    endfunction

    // expected prediction, pc entry before pc+4 entry
    function automatic pred_t predict(bp_pkg::addr_t pc);
        pred_t p;
        int    wp;
        int    wq;
        wp         = find_way(pc);
        wq         = find_way(pc + 32'd4);
        p.hit_pc   = (wp >= 0);
        p.hit_pcp4 = (wq >= 0);
        p.target   = '0;
        p.taken    = 1'b0;
        if (wp >= 0) begin
            p.target = m_target[wp][set_of(pc)];
            p.taken  = (m_ctr[wp][set_of(pc)] >= (1 << (COUNTER_BITS - 1)));
        end else if (wq >= 0) begin
            p.target = m_target[wq][set_of(pc + 32'd4)];
            p.taken  = (m_ctr[wq][set_of(pc + 32'd4)] >= (1 << (COUNTER_BITS - 1)));
        end
        return p;
    endfunction

    function automatic bp_pkg::addr_t random_pc();
        return bp_pkg::addr_t'($random(seed)) & 32'h0000_03fc;
    endfunction

    task automatic check_addr(input string what, input bp_pkg::addr_t exp,
                              input bp_pkg::addr_t act);
        if (act !== exp) begin
            addr_errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            count_errors++;
            $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[w][s] = 1'b0;
            end
            m_plru[s] = '0;
        end
        pending.delete();
    endtask

    task automatic compare_outputs();
        pred_t exp;
        exp = predict(pred_pc);
        check_flag("hit_pc", exp.hit_pc, hit_pc);
        check_flag("hit_pcp4", exp.hit_pcp4, hit_pcp4);
        check_flag("hit", exp.hit_pc || exp.hit_pcp4, hit);
        check_addr("pred_target", exp.target, pred_target);
        check_flag("pred_taken", exp.taken, pred_taken);
        check_flag("upd_credit", pending.size() != 0, upd_credit);
    endtask

    // what the coming edge does: retire one entry, touch, accept
    task automatic advance_model();
        bp_pkg::upd_entry_t e;
        int                 wp;
        int                 wq;
        int                 w;
        int                 s;
        int                 t_set;
        int                 t_way;
        int                 a_set;
        int                 a_way;
        bit                 alloc;
        wp    = find_way(pred_pc);
        wq    = find_way(pred_pc + 32'd4);
        t_set = (wp >= 0) ? set_of(pred_pc) : set_of(pred_pc + 32'd4);
        t_way = (wp >= 0) ? wp : wq;
        alloc = 1'b0;
        a_set = 0;
        a_way = 0;
        if (pending.size() != 0) begin
            e = pending.pop_front();
            retired_count++;
            s = set_of(e.pc);
            w = find_way(e.pc);
            if (w >= 0) begin
                if (e.taken && m_ctr[w][s] < CTR_MAX) begin
                    m_ctr[w][s]++;
                end else if (!e.taken && m_ctr[w][s] > 0) begin
                    m_ctr[w][s]--;
                end
            end else if (e.taken) begin
                alloc             = 1'b1;
                a_set             = s;
                a_way             = victim_of(m_plru[s]);
                m_valid[a_way][s] = 1'b1;
                m_tag[a_way][s]    = tag_part(e.pc);
                m_target[a_way][s] = e.target;
                m_ctr[a_way][s]    = CTR_MAX;
            end
        end
        if (t_way >= 0 && !(alloc && a_set == t_set)) begin
            m_plru[t_set] = touched(m_plru[t_set], t_way);
        end
        if (alloc) begin
            m_plru[a_set] = touched(m_plru[a_set], a_way);
        end
        if (upd_valid) begin
            e = '{pc: upd_pc, target: upd_target, taken: upd_taken};
            pending.push_back(e);
        end
    endtask

    // outputs are settled half a period after the drive
    always @(negedge clk) begin
        if (reset !== 1'b0) begin
            clear_model();
        end else begin
            compare_outputs();
            if (upd_credit) begin
                credits++;
                returned_count++;
            end
            advance_model();
        end
    end

    task automatic tick();
        @(posedge clk);
        #(STIM_DELAY);
    endtask

    task automatic send_update(input bp_pkg::addr_t pc, input bp_pkg::addr_t target,
                               input logic taken);
        upd_valid = 1'b0;
        while (credits == 0) begin
            tick();
        end
        upd_valid  = 1'b1;
        upd_pc     = pc;
        upd_target = target;
        upd_taken  = taken;
        credits--;
        sent_count++;
        tick();
        upd_valid = 1'b0;
    endtask

    // queue is empty once every credit is back
    task automatic drain();
        upd_valid = 1'b0;
        while (credits != UPD_DEPTH) begin
            tick();
        end
    endtask

    task automatic expect_pred(input bp_pkg::addr_t pc, input logic e_pc, input logic e_pcp4,
                               input bp_pkg::addr_t e_target, input logic e_taken);
        pred_pc = pc;
        @(negedge clk);
        check_flag("hit_pc", e_pc, hit_pc);
        check_flag("hit_pcp4", e_pcp4, hit_pcp4);
        check_flag("hit", e_pc || e_pcp4, hit);
        check_addr("pred_target", e_target, pred_target);
        check_flag("pred_taken", e_taken, pred_taken);
        tick();
        pred_pc = IDLE_PC;
    endtask

    initial begin
        seed           = 32'hb0aee1cf;
        test_name      = "reset";
        credits        = UPD_DEPTH;
        sent_count     = 0;
        returned_count = 0;
        retired_count  = 0;
        addr_errors    = 0;
        flag_errors    = 0;
        count_errors   = 0;
        reset          = 1'b1;
        pred_pc        = IDLE_PC;
        upd_valid      = 1'b0;
        upd_pc         = '0;
        upd_target     = '0;
        upd_taken      = 1'b0;
        repeat (3) @(posedge clk);
        #(STIM_DELAY);
        reset = 1'b0;

        test_name = "reset_miss";
        for (int i = 0; i < 8; i++) begin
            expect_pred(bp_pkg::addr_t'($random(seed)), 1'b0, 1'b0, '0, 1'b0);
            check_flag("idle_credit", 1'b0, upd_credit);
        end

        test_name = "allocate";
        send_update(32'h0000_1040, 32'h0000_2000, 1'b1);
        send_update(32'h0000_2044, 32'h0000_2100, 1'b0);
        drain();
        expect_pred(32'h0000_1040, 1'b1, 1'b0, 32'h0000_2000, 1'b1);
        expect_pred(32'h0000_2044, 1'b0, 1'b0, '0, 1'b0);

        test_name = "counter";
        for (int i = 0; i < 6; i++) begin
            send_update(32'h0000_1040, 32'hdead_0000, TRAIN_TAKEN[i]);
            drain();
            expect_pred(32'h0000_1040, 1'b1, 1'b0, 32'h0000_2000, TRAIN_DIR[i]);
        end

        test_name = "pcp4";
        send_update(32'h0000_3084, 32'h0000_4000, 1'b1);
        drain();
        expect_pred(32'h0000_3080, 1'b0, 1'b1, 32'h0000_4000, 1'b1);
        // pc entry trained down to weakly not-taken
        send_update(32'h0000_3080, 32'h0000_5000, 1'b1);
        send_update(32'h0000_3080, 32'h0000_5000, 1'b0);
        send_update(32'h0000_3080, 32'h0000_5000, 1'b0);
        drain();
        expect_pred(32'h0000_3080, 1'b1, 1'b1, 32'h0000_5000, 1'b0);

        test_name = "plru";
        send_update(32'h0008_0014, 32'h0000_6000, 1'b1);
        send_update(32'h0008_0054, 32'h0000_6100, 1'b1);
        send_update(32'h0008_0094, 32'h0000_6200, 1'b1);
        drain();
        expect_pred(32'h0008_0014, 1'b0, 1'b0, '0, 1'b0);
        expect_pred(32'h0008_0094, 1'b1, 1'b0, 32'h0000_6200, 1'b1);
        expect_pred(32'h0008_0054, 1'b1, 1'b0, 32'h0000_6100, 1'b1);
        send_update(32'h0008_00d4, 32'h0000_6300, 1'b1);
        drain();
        expect_pred(32'h0008_0094, 1'b0, 1'b0, '0, 1'b0);
        expect_pred(32'h0008_0054, 1'b1, 1'b0, 32'h0000_6100, 1'b1);
        expect_pred(32'h0008_00d4, 1'b1, 1'b0, 32'h0000_6300, 1'b1);

        test_name = "random";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            pred_pc = random_pc();
            if (credits > 0 && ($random(seed) & 3) != 0) begin
                upd_valid  = 1'b1;
                upd_pc     = random_pc();
                upd_target = bp_pkg::addr_t'($random(seed));
                upd_taken  = (($random(seed) & 3) != 0);
                credits--;
                sent_count++;
            end else begin
                upd_valid = 1'b0;
            end
            tick();
        end
        pred_pc = IDLE_PC;
        drain();
        // every update the model retired must have handed its credit back
        check_count("credits_returned", retired_count, returned_count);

        $display("error counts: target %0d, flag %0d, credit %0d",
                 addr_errors, flag_errors, count_errors);
        if (addr_errors + flag_errors + count_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the run did not finish in time, stuck in test %s", test_name);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- tb.f
design/bp_pkg.sv
design/bp_way_if.sv
design/bp_way.sv
design/bp_hit_merge.sv
design/bp_update_ctrl.sv
design/branch_predictor.sv
test/tb_branch_predictor.sv

//--- Makefile
# Verilator build and run of the branch predictor testbench
# any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

# build, run, then decide by searching the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
